/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core4
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* core4_chk.sv */
// Bound into uop_queue and hazard_unit; each bind turns on only the checks its scope can see
`timescale 1ns/1ps
`default_nettype none

module core4_chk #(
    parameter bit CHECK_WR    = 1'b1,  // Decode strobe is reachable from the bound scope
    parameter bit CHECK_STALL = 1'b1   // stall_fetch is reachable from the bound scope
)(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic wr_req,   // Decode offers a micro-op
    input wire logic full,
    input wire logic stall,
    input wire logic stopped
);

    // ~~~~~~~~~~~~~~~~~~~~
    if (CHECK_WR) begin : g_wr
        a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr_req && full))
            else $error("Micro-op offered while the queue is full");
    end

    if (CHECK_STALL) begin : g_stall
        a_stall_full: assert property (@(posedge clk) disable iff (!rst_n) stall == full)
            else $error("stall_fetch differs from full");
    end

    a_stop_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(stopped))
        else $error("stopped fell without a reset");  // Only reset may clear it

endmodule

bind uop_queue core4_chk #(.CHECK_STALL(1'b0)) u_q_chk (.clk(CLK), .rst_n(rst_n),
    .wr_req(dq.valid), .full(haz.full), .stall(1'b0), .stopped(haz.stopped));

bind hazard_unit core4_chk #(.CHECK_WR(1'b0)) u_h_chk (.clk(CLK), .rst_n(rst_n),
    .wr_req(1'b0), .full(haz.full), .stall(haz.stall_fetch), .stopped(haz.stopped));

`default_nettype wire

/* core4_top.sv */
// Core with plain ports; instruction memory is combinational and external
// ex_hold may be raised at any time and only delays retirement
`timescale 1ns/1ps
`default_nettype none

module core4_top import pipe_cfg_pkg::*; #(
    parameter logic [31:0] RESET_PC    = 32'h0,
    parameter int          QUEUE_DEPTH = 4
)(
    input  wire logic             CLK,
    input  wire logic             rst_n,
    output logic      [31:0]      imem_addr,
    input  wire logic [31:0]      imem_rdata,
    input  wire logic             ex_hold,
    output logic                  wb_valid,
    output logic      [REG_W-1:0] wb_rd,
    output logic      [31:0]      wb_data,
    output logic                  halt
);

    logic        f_valid;
    logic [31:0] f_instr;

    // ~~~~~~~~~~~~~~~~~~~~
    // Interfaces between the stages
    uop_if    dec_q ();  // Decode to queue
    uop_if    q_ex  ();  // Queue head to execute
    hazard_if haz   ();

    assign haz.hold = ex_hold;  // Outside back-pressure goes straight to the queue and execute

    // ~~~~~~~~~~~~~~~~~~~~
    // Stages
    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .CLK(CLK), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .haz(haz), .f_valid(f_valid), .f_instr(f_instr)
    );

    decode_stage u_decode (.f_valid(f_valid), .f_instr(f_instr), .haz(haz), .dq(dec_q));

    uop_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .CLK(CLK), .rst_n(rst_n), .dq(dec_q), .qe(q_ex), .haz(haz)
    );

    execute_stage u_execute (
        .CLK(CLK), .rst_n(rst_n), .qe(q_ex), .haz(haz),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    hazard_unit u_hazard (.CLK(CLK), .rst_n(rst_n), .haz(haz), .halt(halt));

endmodule

`default_nettype wire

/* decode_stage.sv */
// Purely combinational; one instruction becomes exactly one micro-op
// Unsupported encodings, SRA and SLTU included, become micro-ops that write nothing
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_isa_pkg::*, pipe_cfg_pkg::*; (
    input  wire logic        f_valid,
    input  wire logic [31:0] f_instr,
    hazard_if.fetch          haz,
    uop_if.src               dq
);

    instr_u ins;  // The fetch word seen through all three formats

    assign ins = f_instr;

    // A stalled fetch register is written again later, so nothing goes out now
    assign dq.valid = f_valid && !haz.stall_fetch;

    // Register fields sit at the same bit positions in every format
    assign dq.rd  = ins.r.rd;
    assign dq.rs1 = ins.r.rs1;
    assign dq.rs2 = ins.r.rs2;

    always_comb begin
        dq.alu_op  = ALU_ADD;
        dq.imm     = {{20{ins.i.imm12[11]}}, ins.i.imm12};  // I-format sign extension
        dq.use_imm = 1'b0;
        dq.wr_en   = 1'b0;
        dq.halt    = 1'b0;

        case (ins.r.opcode)
            OPC_OP: begin
                dq.wr_en = 1'b1;
                case (ins.r.funct3)
                    F3_ADD:  dq.alu_op = (ins.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:  dq.alu_op = ALU_SLT;
                    F3_XOR:  dq.alu_op = ALU_XOR;
                    F3_OR:   dq.alu_op = ALU_OR;
                    F3_AND:  dq.alu_op = ALU_AND;
                    F3_SLL:  dq.alu_op = ALU_SLL;
                    F3_SRL:  dq.wr_en  = (ins.r.funct7 == 7'd0);  // SRA is not supported
                    default: dq.wr_en  = 1'b0;
                endcase
                if (ins.r.funct3 == F3_SRL) dq.alu_op = ALU_SRL;
            end
            OPC_OP_IMM: begin
                dq.use_imm = 1'b1;
                dq.wr_en   = 1'b1;
                case (ins.i.funct3)
                    F3_ADD:  dq.alu_op = ALU_ADD;
                    F3_SLT:  dq.alu_op = ALU_SLT;
                    F3_XOR:  dq.alu_op = ALU_XOR;
                    F3_OR:   dq.alu_op = ALU_OR;
                    F3_AND:  dq.alu_op = ALU_AND;
                    F3_SLL:  dq.alu_op = ALU_SLL;  // Shift amount is imm[4:0]
                    F3_SRL:  dq.alu_op = ALU_SRL;
                    default: dq.wr_en  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dq.alu_op  = ALU_PASS;
                dq.imm     = {ins.u.imm20, 12'd0};  // Upper immediate, low bits zero
                dq.use_imm = 1'b1;
                dq.wr_en   = 1'b1;
            end
            OPC_SYSTEM: begin
                // EBREAK is the only SYSTEM word with imm12 of 1 and all other fields zero
                dq.halt = (ins.i.imm12 == 12'd1) && (ins.i.rs1 == 5'd0) &&
                          (ins.i.funct3 == 3'd0) && (ins.i.rd == 5'd0);
            end
            default: ;  // Retires as a no-op
        endcase
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
// Register file writes land at the pop edge, so the next micro-op sees them without forwarding
// Nothing is consumed after a halt micro-op has retired
`timescale 1ns/1ps
`default_nettype none

module execute_stage import pipe_cfg_pkg::*; (
    input  wire logic    CLK,
    input  wire logic    rst_n,
    uop_if.dst           qe,
    hazard_if.exec       haz,
    output logic         wb_valid,
    output logic [REG_W-1:0] wb_rd,
    output logic [31:0]  wb_data
);

    logic [31:0] rf [1:31];  // x0 has no storage and reads as zero
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] rs2_val;
    logic [31:0] result;
    logic        fire;       // Micro-op consumed at this edge
    logic        do_wr;      // Consumed micro-op writes a real register
    logic        halted;

    assign fire  = qe.valid && !haz.hold && !halted;
    assign do_wr = fire && qe.wr_en && (qe.rd != '0);

    // ~~~~~~~~~~~~~~~~~~~~
    // Operand read
    assign op_a    = (qe.rs1 == '0) ? 32'd0 : rf[qe.rs1];
    assign rs2_val = (qe.rs2 == '0) ? 32'd0 : rf[qe.rs2];
    assign op_b    = qe.use_imm ? qe.imm : rs2_val;

    // ALU
    always_comb begin
        case (qe.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLL:  result = op_a << op_b[4:0];  // Only the low 5 bits shift
            ALU_SRL:  result = op_a >> op_b[4:0];
            ALU_PASS: result = op_b;
            default:  result = 32'd0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Writeback
    always_ff @(posedge CLK) begin
        if (do_wr) rf[qe.rd] <= result;
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= do_wr;                          // One strobe per retirement
            halted   <= halted || (fire && qe.halt);    // Sticky until reset
        end
    end

    // Port payload follows the strobe
    always_ff @(posedge CLK) begin
        if (do_wr) begin
            wb_rd   <= qe.rd;
            wb_data <= result;
        end
    end

    assign haz.halt_retired = halted;

endmodule

`default_nettype wire

/* fetch_stage.sv */
// Instruction memory must answer combinationally in the same cycle as imem_addr
// No branches, so the PC only ever steps by 4
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] RESET_PC = 32'h0
)(
    input  wire logic        CLK,
    input  wire logic        rst_n,
    output logic      [31:0] imem_addr,
    input  wire logic [31:0] imem_rdata,
    hazard_if.fetch          haz,
    output logic             f_valid,
    output logic      [31:0] f_instr
);

    logic [31:0] pc;
    logic        advance;  // Take a new word this cycle

    assign advance   = !haz.stall_fetch && !haz.stopped;
    assign imem_addr = pc;  // Memory reads straight from the PC

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            f_valid <= 1'b0;
        end else if (haz.stopped) begin
            f_valid <= 1'b0;  // Decode goes quiet once halted, PC stays frozen
        end else if (advance) begin
            pc      <= pc + 32'd4;
            f_valid <= 1'b1;
        end
    end

    // Instruction word is held together with the PC on a stall
    always_ff @(posedge CLK) begin
        if (advance) f_instr <= imem_rdata;
    end

endmodule

`default_nettype wire

/* hazard_unit.sv */
// Only stalls and halt; the core has no branches or loads to forward or flush
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire logic CLK,
    input  wire logic rst_n,
    hazard_if.ctrl    haz,
    output logic      halt
);

    logic stopped_q;

    // Fetch and decode wait exactly while the queue has no room
    assign haz.stall_fetch = haz.full;

    // Stop one cycle after the halt micro-op retires, and stay stopped
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            stopped_q <= 1'b0;
        end else if (haz.halt_retired) begin
            stopped_q <= 1'b1;
        end
    end

    assign haz.stopped = stopped_q;
    assign halt        = stopped_q;  // Visible to the outside world

endmodule

`default_nettype wire

/* pipe_cfg_pkg.sv */
// Micro-op encoding of the core; ALU codes are internal and not tied to any ISA field
`default_nettype none

package pipe_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Field widths
    localparam int ALU_OP_W = 4;  // Room for up to 16 ALU operations
    localparam int REG_W    = 5;  // 32 architectural registers

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd5;  // Signed compare
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_PASS = 4'd8;  // Second operand straight through, for LUI

endpackage

`default_nettype wire

/* pipe_ifs.sv */
// Both bundles are purely combinational and carry no clock
// uop_if valid is a plain strobe; the consumer never pushes back through it
`timescale 1ns/1ps
`default_nettype none

// One micro-op between decode, queue and execute
interface uop_if import pipe_cfg_pkg::*; ();

    logic                valid;   // Micro-op present this cycle
    logic [ALU_OP_W-1:0] alu_op;
    logic [REG_W-1:0]    rd;
    logic [REG_W-1:0]    rs1;
    logic [REG_W-1:0]    rs2;
    logic [31:0]         imm;     // Already extended or shifted by decode
    logic                use_imm; // Second ALU operand is imm instead of rs2
    logic                wr_en;   // Result goes to rd
    logic                halt;    // EBREAK

    // Producer side
    modport src (
        output valid, alu_op, rd, rs1, rs2, imm, use_imm, wr_en, halt
    );

    // Consumer side
    modport dst (
        input valid, alu_op, rd, rs1, rs2, imm, use_imm, wr_en, halt
    );

endinterface

// Stall and halt control shared by all stages
interface hazard_if;

    logic full;          // Micro-op queue has no free slot
    logic hold;          // Execute back-pressure from outside
    logic halt_retired;  // A halt micro-op has left execute
    logic stall_fetch;   // Freeze PC, fetch register and decode
    logic stopped;       // Core is halted for good until reset

    modport ctrl  (input full, halt_retired, output stall_fetch, stopped);
    modport fetch (input stall_fetch, stopped);
    modport queue (input hold, stopped, output full);
    modport exec  (input hold, output halt_retired);

endinterface

`default_nettype wire

/* rv_isa_pkg.sv */
// RV32I encodings for the supported subset only; no branch, load, store or CSR encodings
// The union shares one 32-bit word between the R, I and U formats
`default_nettype none

package rv_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;  // Load upper immediate
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;  // Only EBREAK is recognised here

    // ~~~~~~~~~~~~~~~~~~~~
    // funct3 values shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000;  // Turns ADD into SUB in the R format

    // Three views of the same instruction word, MSB first
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;  // Also carries shamt in its low 5 bits
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } instr_u;

endpackage

`default_nettype wire

/* src.f */
rv_isa_pkg.sv
pipe_cfg_pkg.sv
pipe_ifs.sv
fetch_stage.sv
decode_stage.sv
uop_queue.sv
execute_stage.sv
hazard_unit.sv
core4_top.sv
core4_chk.sv
tb_core4.sv

/* tb_core4.sv */
// Directed testbench for core4_top; the ROM wraps every 64 words and the DUT runs from RESET_PC
// The DUT register file has no reset, so each program writes a register before reading it
`timescale 1ns/1ps
`default_nettype none

module tb_core4 import rv_isa_pkg::*, pipe_cfg_pkg::*;;

    localparam logic [31:0] RESET_PC = 32'h40;
    localparam logic [31:0] EBREAK   = {12'd1, 5'd0, 3'd0, 5'd0, OPC_SYSTEM};

    logic             clk;
    logic             rst_n;
    logic      [31:0] imem_addr;
    logic      [31:0] imem_rdata;
    logic             ex_hold;
    logic             wb_valid;
    logic [REG_W-1:0] wb_rd;
    logic      [31:0] wb_data;
    logic             halt;

    logic [31:0] rom [64];
    logic [31:0] prog [$];  // Program under test, placed at RESET_PC
    logic [63:0] exp_wb [$];  // {rd, data} from the reference model
    logic [63:0] got_wb [$];  // {rd, data} seen on the writeback port
    integer      seed;

    core4_top #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(4)) uut (
        .CLK(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .ex_hold(ex_hold), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .halt(halt)
    );

    assign imem_rdata = rom[imem_addr[7:2]];  // Combinational ROM as the core expects

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Writeback payload is stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && wb_valid) got_wb.push_back({27'd0, wb_rd, wb_data});
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Assembler helpers
    function automatic logic [31:0] op_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] op_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] op_lui(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // One random supported ALU instruction over x0..x7
    function automatic logic [31:0] rand_instr();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r1  = $random(seed);
        r2  = $random(seed);
        rd  = {2'b00, r1[2:0]};
        rs1 = {2'b00, r1[5:3]};
        rs2 = {2'b00, r1[8:6]};
        case (r1[12:9])
            4'd0:    return op_i(r2[11:0], rs1, F3_ADD, rd);
            4'd1:    return op_i(r2[11:0], rs1, F3_AND, rd);
            4'd2:    return op_i(r2[11:0], rs1, F3_OR, rd);
            4'd3:    return op_i(r2[11:0], rs1, F3_XOR, rd);
            4'd4:    return op_i(r2[11:0], rs1, F3_SLT, rd);
            4'd5:    return op_i({7'd0, r2[4:0]}, rs1, F3_SLL, rd);
            4'd6:    return op_i({7'd0, r2[4:0]}, rs1, F3_SRL, rd);
            4'd7:    return op_r(7'd0, rs2, rs1, F3_ADD, rd);
            4'd8:    return op_r(F7_SUB, rs2, rs1, F3_ADD, rd);
            4'd9:    return op_r(7'd0, rs2, rs1, F3_AND, rd);
            4'd10:   return op_r(7'd0, rs2, rs1, F3_OR, rd);
            4'd11:   return op_r(7'd0, rs2, rs1, F3_XOR, rd);
            4'd12:   return op_r(7'd0, rs2, rs1, F3_SLT, rd);
            4'd13:   return op_r(7'd0, rs2, rs1, F3_SLL, rd);
            4'd14:   return op_r(7'd0, rs2, rs1, F3_SRL, rd);
            default: return op_lui(r2[31:12], rd);
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // ROM loading and reference model
    task automatic load_rom();
        for (int i = 0; i < 64; i++) begin
            rom[i] = op_i(12'(i), 5'd0, F3_ADD, 5'd0);  // Filler writes x0 with its own index
        end
        foreach (prog[i]) rom[(int'(RESET_PC[7:2]) + i) % 64] = prog[i];
    endtask

    // Runs the ROM in program order up to EBREAK and lists the expected writebacks
    task automatic model_run();
        logic [31:0] regs [32];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        foreach (regs[i]) regs[i] = 32'd0;
        exp_wb.delete();
        for (int n = 0; n < 64; n++) begin
            w = rom[(int'(RESET_PC[7:2]) + n) % 64];
            if (w == EBREAK) break;
            a   = regs[w[19:15]];
            b   = (w[6:0] == OPC_OP) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
            wr  = (w[6:0] == OPC_OP) || (w[6:0] == OPC_OP_IMM);
            res = 32'd0;
            case (w[14:12])
                F3_ADD:  res = (w[6:0] == OPC_OP && w[31:25] == F7_SUB) ? a - b : a + b;
                F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F3_XOR:  res = a ^ b;
                F3_OR:   res = a | b;
                F3_AND:  res = a & b;
                F3_SLL:  res = a << b[4:0];
                F3_SRL:  res = a >> b[4:0];
                default: wr = 1'b0;
            endcase
            if (w[6:0] == OPC_LUI) begin
                res = {w[31:12], 12'd0};
                wr  = 1'b1;
            end
            if (wr && w[11:7] != 5'd0) begin  // x0 stays zero and never retires a writeback
                regs[w[11:7]] = res;
                exp_wb.push_back({27'd0, w[11:7], res});
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Checking
    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic reset_core();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    // Loads the program, resets the core, waits for halt and compares the writebacks
    task automatic run_test(input string name, input int hold_at, input bit rand_hold);
        int          cycles;
        logic [31:0] r;
        load_rom();
        model_run();
        ex_hold = 1'b0;
        reset_core();
        got_wb.delete();
        cycles = 0;
        while (halt !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (rand_hold) begin
                r       = $random(seed);
                ex_hold = (r[1:0] == 2'b00);  // Hold about one cycle in four
            end else begin
                ex_hold = (hold_at > 0) && (cycles >= hold_at) && (cycles < hold_at + 20);
            end
            if (cycles > 600) begin
                $display("Timeout while waiting for halt in test %s", name);
                stop_on_error();
            end
        end
        ex_hold = 1'b0;
        repeat (6) begin  // Halt must stay up and nothing more may retire
            @(posedge clk);
            #1;
            check_eq({name, " halt"}, 64'd1, {63'd0, halt});
        end
        foreach (got_wb[i]) begin
            if (i >= exp_wb.size()) begin
                $display("Test %s saw more writebacks than the program produces", name);
                stop_on_error();
            end
            check_eq({name, " writeback"}, exp_wb[i], got_wb[i]);
        end
        check_eq({name, " count"}, 64'(exp_wb.size()), 64'(got_wb.size()));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    task automatic test_reset();
        rst_n = 1'b0;
        @(posedge clk);
        #1;
        check_eq("reset wb_valid", 64'd0, {63'd0, wb_valid});
        check_eq("reset halt", 64'd0, {63'd0, halt});
        check_eq("reset imem_addr", {32'd0, RESET_PC}, {32'd0, imem_addr});
        @(posedge clk);
        #1 rst_n = 1'b1;
        check_eq("after reset wb_valid", 64'd0, {63'd0, wb_valid});
        check_eq("after reset halt", 64'd0, {63'd0, halt});
        check_eq("after reset imem_addr", {32'd0, RESET_PC}, {32'd0, imem_addr});
    endtask

    task automatic test_imm();
        prog = '{op_i(12'hffb, 5'd0, F3_ADD, 5'd1),  // x1 = -5
                 op_i(12'h0f0, 5'd1, F3_AND, 5'd2),
                 op_i(12'h123, 5'd1, F3_OR, 5'd3),
                 op_i(12'hfff, 5'd1, F3_XOR, 5'd4),
                 op_i(12'hffd, 5'd1, F3_SLT, 5'd5),  // -5 < -3
                 op_i(12'hff7, 5'd1, F3_SLT, 5'd6),  // -5 < -9 is false
                 op_i(12'h004, 5'd1, F3_SLL, 5'd7),
                 op_i(12'h01c, 5'd1, F3_SRL, 5'd8),
                 op_lui(20'habcde, 5'd9),
                 EBREAK};
        run_test("imm", 0, 1'b0);
    endtask

    task automatic build_chain();
        prog = '{op_i(12'd100, 5'd0, F3_ADD, 5'd1),
                 op_i(12'd7, 5'd0, F3_ADD, 5'd2),
                 op_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3),
                 op_r(F7_SUB, 5'd2, 5'd3, F3_ADD, 5'd4),
                 op_r(7'd0, 5'd3, 5'd4, F3_AND, 5'd5),
                 op_r(7'd0, 5'd2, 5'd5, F3_OR, 5'd6),
                 op_r(7'd0, 5'd1, 5'd6, F3_XOR, 5'd7),
                 op_r(7'd0, 5'd6, 5'd7, F3_SLT, 5'd8),
                 op_r(7'd0, 5'd2, 5'd7, F3_SLL, 5'd9),
                 op_r(7'd0, 5'd8, 5'd9, F3_SRL, 5'd10),
                 op_i(12'd5, 5'd10, F3_ADD, 5'd0),  // Write to x0 gives no writeback
                 op_r(7'd0, 5'd10, 5'd0, F3_ADD, 5'd11),  // x0 reads as zero
                 EBREAK};
    endtask

    task automatic test_random();
        logic [31:0] r;
        prog.delete();
        for (int i = 1; i < 8; i++) begin  // Seed x1..x7 before random reads
            r = $random(seed);
            prog.push_back(op_i(r[11:0], 5'd0, F3_ADD, 5'(i)));
        end
        repeat (30) prog.push_back(rand_instr());
        prog.push_back(EBREAK);
        run_test("random", 0, 1'b1);
    endtask

    task automatic test_halt();
        prog = '{op_i(12'd1, 5'd0, F3_ADD, 5'd1),
                 EBREAK,
                 op_i(12'd2, 5'd0, F3_ADD, 5'd2),  // Never retires
                 op_i(12'd3, 5'd0, F3_ADD, 5'd3)};
        run_test("halt", 0, 1'b0);
    endtask

    initial begin
        seed    = 32'hd7e6;
        rst_n   = 1'b0;
        ex_hold = 1'b0;
        prog.delete();
        load_rom();
        @(posedge clk);
        #1;
        test_reset();
        test_imm();
        build_chain();
        run_test("chain", 0, 1'b0);
        build_chain();
        run_test("backpressure", 6, 1'b0);  // Twenty held cycles starting mid-program
        test_random();
        test_halt();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* uop_queue.sv */
// QUEUE_DEPTH must be a power of two and at least 2
// Writes arriving while full are dropped, so the writer must honour full
`timescale 1ns/1ps
`default_nettype none

module uop_queue import pipe_cfg_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
)(
    input  wire logic CLK,
    input  wire logic rst_n,
    uop_if.dst        dq,
    uop_if.src        qe,
    hazard_if.queue   haz
);

    localparam int AW      = $clog2(QUEUE_DEPTH);
    localparam int ENTRY_W = ALU_OP_W + 3*REG_W + 32 + 3;  // All micro-op fields except valid

    logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
    logic [AW:0]        wr_ptr;  // Extra MSB tells full from empty
    logic [AW:0]        rd_ptr;
    logic               empty;
    logic               push;
    logic               pop;

    // ~~~~~~~~~~~~~~~~~~~~
    // Status
    assign empty    = (wr_ptr == rd_ptr);
    assign haz.full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign push     = dq.valid && !haz.full && !haz.stopped;
    assign pop      = !empty && !haz.hold;  // Same condition execute uses to consume

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (haz.stopped) begin
            wr_ptr <= '0;  // Anything left behind a halt is thrown away
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= {dq.alu_op, dq.rd, dq.rs1, dq.rs2, dq.imm,
                                    dq.use_imm, dq.wr_en, dq.halt};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Head of the queue, valid whenever something is stored
    assign qe.valid = !empty;
    assign {qe.alu_op, qe.rd, qe.rs1, qe.rs2, qe.imm,
            qe.use_imm, qe.wr_en, qe.halt} = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire
